/* design/issue_pkg.sv */
/*
 * issue stage package
 * register widths, function-unit encoding and the clobber vector type
 */
package issue_pkg;

  // register index width and architectural register count
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS = 32;

  // scoreboard transaction id
  localparam int unsigned TRANS_ID_W = 3;

  // operation code, carried through untouched
  localparam int unsigned OP_W = 7;

  // function unit that executes an instruction
  typedef enum logic [2:0] {
    NONE      = 3'd0,
    ALU       = 3'd1,
    CTRL_FLOW = 3'd2,
    MULT      = 3'd3,
    LOAD      = 3'd4,
    STORE     = 3'd5,
    CSR       = 3'd6
  } fu_t;

  // next writer per register
  // NONE means no write is pending for that register
  typedef fu_t [NR_REGS-1:0] clobber_vec_t;

endpackage

/* design/issue_instr_if.sv */
/*
 * decoded instruction bundle
 * carries one decoder entry from the top level into the issue blocks
 */
`timescale 1ns/1ns

interface issue_instr_if #(
  parameter int unsigned XLEN = 64
);
  import issue_pkg::*;

  logic                  valid;
  fu_t                   fu;
  logic [OP_W-1:0]       op;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       pc;
  // operand steering flags from the decoder
  logic                  use_pc;
  logic                  use_zimm;
  logic                  use_imm;
  // instruction already carries an exception
  logic                  ex_valid;
  logic [TRANS_ID_W-1:0] trans_id;

  modport src (output valid, fu, op, rs1, rs2, rd, imm, pc,
               use_pc, use_zimm, use_imm, ex_valid, trans_id);
  modport dst (input valid, fu, op, rs1, rs2, rd, imm, pc,
               use_pc, use_zimm, use_imm, ex_valid, trans_id);

endinterface

/* design/int_regfile.sv */
/*
 * integer register file
 * two combinational read ports, commit write ports, x0 hardwired to zero
 */
`timescale 1ns/1ns

module int_regfile #(
  parameter int unsigned XLEN = 64,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_uarch_ni,
  input  logic [issue_pkg::REG_ADDR_W-1:0]                     raddr_a_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]                     raddr_b_i,
  output logic [XLEN-1:0]                                      rdata_a_o,
  output logic [XLEN-1:0]                                      rdata_b_o,
  input  logic [NR_COMMIT_PORTS-1:0][issue_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]                 wdata_i,
  input  logic [NR_COMMIT_PORTS-1:0]                           we_i
);
  import issue_pkg::*;

  logic [XLEN-1:0] regs_q [NR_REGS];

  // write side
  // ports are walked low to high, so the last matching port takes the register
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      for (int unsigned r = 0; r < NR_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
        // x0 is never written
        if (we_i[p] && (waddr_i[p] != '0)) begin
          regs_q[waddr_i[p]] <= wdata_i[p];
        end
      end
    end
  end

  // read side, no write-to-read bypass
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* design/hazard_check.sv */
/*
 * issue hazard check
 * source clobber and forwarding, unit busy, WAW check and issue acknowledge
 */
`timescale 1ns/1ns

module hazard_check #(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  issue_instr_if.dst                                            instr,
  input  issue_pkg::clobber_vec_t                               clobber_i,
  input  logic                                                  fwd_rs1_valid_i,
  input  logic                                                  fwd_rs2_valid_i,
  input  logic                                                  stall_i,
  input  logic                                                  flu_ready_i,
  input  logic                                                  lsu_ready_i,
  input  logic                                                  mult_valid_i,
  input  logic [NR_COMMIT_PORTS-1:0][issue_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [NR_COMMIT_PORTS-1:0]                            we_i,
  output logic                                                  forward_rs1_o,
  output logic                                                  forward_rs2_o,
  output logic                                                  stall_issue_o,
  output logic                                                  issue_ack_o
);
  import issue_pkg::*;

  fu_t  rs1_writer;
  fu_t  rs2_writer;
  logic src_stall;
  logic fu_busy;
  logic rd_free;

  // pending writers of both sources
  assign rs1_writer = clobber_i[instr.rs1];
  assign rs2_writer = clobber_i[instr.rs2];

  // --------------------------------------------------------------------------
  // source operands
  // --------------------------------------------------------------------------
  // a clobbered source is forwarded when the scoreboard has the result,
  // csr results only ever come through the register file
  always_comb begin : source_check
    forward_rs1_o = 1'b0;
    forward_rs2_o = 1'b0;
    src_stall     = 1'b0;
    // zimm puts an immediate in rs1, nothing to wait for
    if (!instr.use_zimm && (rs1_writer != NONE)) begin
      if (fwd_rs1_valid_i && (rs1_writer != CSR)) begin
        forward_rs1_o = 1'b1;
      end else begin
        src_stall = 1'b1;
      end
    end
    if (rs2_writer != NONE) begin
      if (fwd_rs2_valid_i && (rs2_writer != CSR)) begin
        forward_rs2_o = 1'b1;
      end else begin
        src_stall = 1'b1;
      end
    end
  end

  assign stall_issue_o = stall_i | src_stall;

  // busy flag of the unit this instruction needs
  always_comb begin : unit_busy
    case (instr.fu)
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // WAW check and acknowledge
  // --------------------------------------------------------------------------
  // rd is free when nobody is pending on it
  // or a commit port retires its writer this very cycle
  always_comb begin : waw_check
    rd_free = (clobber_i[instr.rd] == NONE);
    for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
      if (we_i[p] && (waddr_i[p] == instr.rd)) begin
        rd_free = 1'b1;
      end
    end
  end

  always_comb begin : issue_ack
    issue_ack_o = 1'b0;
    if (instr.valid) begin
      if (!stall_issue_o && !fu_busy && rd_free) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less instructions go straight through
      if (instr.ex_valid || (instr.fu == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // the fixed latency result bus is taken right after a multiplication
    if (mult_valid_i && (instr.fu inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

  always_comb begin : ack_needs_valid
    if (!instr.valid) begin
      assert (!issue_ack_o)
        else $error("issue acknowledged without a valid instruction");
    end
  end

endmodule

/* design/operand_select.sv */
/*
 * operand select
 * forwarding mux and pc, zimm and immediate steering for operands a and b
 */
`timescale 1ns/1ns

module operand_select #(
  parameter int unsigned XLEN = 64
) (
  issue_instr_if.dst       instr,
  input  logic [XLEN-1:0]  rdata_a_i,
  input  logic [XLEN-1:0]  rdata_b_i,
  input  logic [XLEN-1:0]  fwd_rs1_data_i,
  input  logic [XLEN-1:0]  fwd_rs2_data_i,
  input  logic             forward_rs1_i,
  input  logic             forward_rs2_i,
  output logic [XLEN-1:0]  operand_a_o,
  output logic [XLEN-1:0]  operand_b_o,
  output logic [XLEN-1:0]  imm_o
);
  import issue_pkg::*;

  // operand a: register or forwarded value, then pc, then zimm
  always_comb begin : operand_a_mux
    operand_a_o = forward_rs1_i ? fwd_rs1_data_i : rdata_a_i;
    if (instr.use_pc) begin
      operand_a_o = instr.pc;
    end
    // zimm is the rs1 index, zero extended
    if (instr.use_zimm) begin
      operand_a_o = {{(XLEN-REG_ADDR_W){1'b0}}, instr.rs1};
    end
  end

  // operand b: register or forwarded value, or the immediate
  // stores and branches keep rs2 here and take the immediate separately
  always_comb begin : operand_b_mux
    operand_b_o = forward_rs2_i ? fwd_rs2_data_i : rdata_b_i;
    if (instr.use_imm && (instr.fu != STORE) && (instr.fu != CTRL_FLOW)) begin
      operand_b_o = instr.imm;
    end
  end

  assign imm_o = instr.imm;

endmodule

/* design/fu_dispatch.sv */
/*
 * function unit dispatch
 * ID/EX registers and the one-hot unit valids raised one cycle after issue
 */
`timescale 1ns/1ns

module fu_dispatch #(
  parameter int unsigned XLEN = 64
) (
  input  logic                            clk_i,
  input  logic                            rst_uarch_ni,
  input  logic                            flush_i,
  issue_instr_if.dst                      instr,
  input  logic                            issue_ack_i,
  input  logic [XLEN-1:0]                 operand_a_i,
  input  logic [XLEN-1:0]                 operand_b_i,
  input  logic [XLEN-1:0]                 imm_i,
  output logic [XLEN-1:0]                 operand_a_o,
  output logic [XLEN-1:0]                 operand_b_o,
  output logic [XLEN-1:0]                 imm_o,
  output issue_pkg::fu_t                  fu_o,
  output logic [issue_pkg::OP_W-1:0]      op_o,
  output logic [issue_pkg::TRANS_ID_W-1:0] trans_id_o,
  output logic [XLEN-1:0]                 pc_o,
  output logic                            alu_valid_o,
  output logic                            branch_valid_o,
  output logic                            mult_valid_o,
  output logic                            lsu_valid_o,
  output logic                            csr_valid_o
);
  import issue_pkg::*;

  logic dispatch;

  // an exception is acked but never started on a unit
  assign dispatch = instr.valid && issue_ack_i && !instr.ex_valid && !flush_i;

  // --------------------------------------------------------------------------
  // ID/EX registers, loaded every cycle
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      operand_a_o <= '0;
      operand_b_o <= '0;
      imm_o       <= '0;
      fu_o        <= NONE;
      op_o        <= '0;
      trans_id_o  <= '0;
      pc_o        <= '0;
    end else begin
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
      imm_o       <= imm_i;
      fu_o        <= instr.fu;
      op_o        <= instr.op;
      trans_id_o  <= instr.trans_id;
      pc_o        <= instr.pc;
    end
  end

  // one-hot unit valids, single cycle pulses
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      mult_valid_o   <= 1'b0;
      lsu_valid_o    <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      alu_valid_o    <= dispatch && (instr.fu == ALU);
      branch_valid_o <= dispatch && (instr.fu == CTRL_FLOW);
      mult_valid_o   <= dispatch && (instr.fu == MULT);
      lsu_valid_o    <= dispatch && (instr.fu inside {LOAD, STORE});
      csr_valid_o    <= dispatch && (instr.fu == CSR);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
    $onehot0({alu_valid_o, branch_valid_o, mult_valid_o, lsu_valid_o, csr_valid_o}))
    else $error("more than one unit valid raised");

endmodule

/* design/issue_read_operands.sv */
/*
 * issue and read operands stage
 * decides issue, reads and forwards operands, registers them toward execute
 */
`timescale 1ns/1ns

module issue_read_operands #(
  parameter int unsigned XLEN = 64,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_uarch_ni,
  input  logic                                                  flush_i,
  input  logic                                                  stall_i,
  // decoded instruction
  input  logic                                                  instr_valid_i,
  input  issue_pkg::fu_t                                        fu_i,
  input  logic [issue_pkg::OP_W-1:0]                            op_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]                      rs1_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]                      rs2_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]                      rd_i,
  input  logic [XLEN-1:0]                                       imm_i,
  input  logic [XLEN-1:0]                                       pc_i,
  input  logic                                                  use_pc_i,
  input  logic                                                  use_zimm_i,
  input  logic                                                  use_imm_i,
  input  logic                                                  ex_valid_i,
  input  logic [issue_pkg::TRANS_ID_W-1:0]                      trans_id_i,
  output logic                                                  issue_ack_o,
  output logic                                                  stall_issue_o,
  // scoreboard lookup
  output logic [issue_pkg::REG_ADDR_W-1:0]                      rs1_o,
  output logic [issue_pkg::REG_ADDR_W-1:0]                      rs2_o,
  input  logic [XLEN-1:0]                                       fwd_rs1_data_i,
  input  logic                                                  fwd_rs1_valid_i,
  input  logic [XLEN-1:0]                                       fwd_rs2_data_i,
  input  logic                                                  fwd_rs2_valid_i,
  input  issue_pkg::clobber_vec_t                               clobber_i,
  // unit ready
  input  logic                                                  flu_ready_i,
  input  logic                                                  lsu_ready_i,
  // commit write ports
  input  logic [NR_COMMIT_PORTS-1:0][issue_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]                  wdata_i,
  input  logic [NR_COMMIT_PORTS-1:0]                            we_i,
  // toward execute
  output logic [XLEN-1:0]                                       operand_a_o,
  output logic [XLEN-1:0]                                       operand_b_o,
  output logic [XLEN-1:0]                                       imm_o,
  output issue_pkg::fu_t                                        fu_o,
  output logic [issue_pkg::OP_W-1:0]                            op_o,
  output logic [issue_pkg::TRANS_ID_W-1:0]                      trans_id_o,
  output logic [XLEN-1:0]                                       pc_o,
  output logic                                                  alu_valid_o,
  output logic                                                  branch_valid_o,
  output logic                                                  mult_valid_o,
  output logic                                                  lsu_valid_o,
  output logic                                                  csr_valid_o
);

  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  logic            forward_rs1;
  logic            forward_rs2;
  logic [XLEN-1:0] operand_a_n;
  logic [XLEN-1:0] operand_b_n;
  logic [XLEN-1:0] imm_n;

  issue_instr_if #(.XLEN(XLEN)) instr ();

  // --------------------------------------------------------------------------
  // decoder entry onto the instruction bundle
  // --------------------------------------------------------------------------
  assign instr.valid    = instr_valid_i;
  assign instr.fu       = fu_i;
  assign instr.op       = op_i;
  assign instr.rs1      = rs1_i;
  assign instr.rs2      = rs2_i;
  assign instr.rd       = rd_i;
  assign instr.imm      = imm_i;
  assign instr.pc       = pc_i;
  assign instr.use_pc   = use_pc_i;
  assign instr.use_zimm = use_zimm_i;
  assign instr.use_imm  = use_imm_i;
  assign instr.ex_valid = ex_valid_i;
  assign instr.trans_id = trans_id_i;

  // scoreboard is polled with the same source indices
  assign rs1_o = instr.rs1;
  assign rs2_o = instr.rs2;

  int_regfile #(
    .XLEN            (XLEN),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) int_regfile_i (
    .clk_i        (clk_i),
    .rst_uarch_ni (rst_uarch_ni),
    .raddr_a_i    (instr.rs1),
    .raddr_b_i    (instr.rs2),
    .rdata_a_o    (rdata_a),
    .rdata_b_o    (rdata_b),
    .waddr_i      (waddr_i),
    .wdata_i      (wdata_i),
    .we_i         (we_i)
  );

  hazard_check #(
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) hazard_check_i (
    .instr           (instr),
    .clobber_i       (clobber_i),
    .fwd_rs1_valid_i (fwd_rs1_valid_i),
    .fwd_rs2_valid_i (fwd_rs2_valid_i),
    .stall_i         (stall_i),
    .flu_ready_i     (flu_ready_i),
    .lsu_ready_i     (lsu_ready_i),
    .mult_valid_i    (mult_valid_o),
    .waddr_i         (waddr_i),
    .we_i            (we_i),
    .forward_rs1_o   (forward_rs1),
    .forward_rs2_o   (forward_rs2),
    .stall_issue_o   (stall_issue_o),
    .issue_ack_o     (issue_ack_o)
  );

  operand_select #(
    .XLEN (XLEN)
  ) operand_select_i (
    .instr          (instr),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .fwd_rs1_data_i (fwd_rs1_data_i),
    .fwd_rs2_data_i (fwd_rs2_data_i),
    .forward_rs1_i  (forward_rs1),
    .forward_rs2_i  (forward_rs2),
    .operand_a_o    (operand_a_n),
    .operand_b_o    (operand_b_n),
    .imm_o          (imm_n)
  );

  // registered mult valid also feeds the issue rule above
  fu_dispatch #(
    .XLEN (XLEN)
  ) fu_dispatch_i (
    .clk_i          (clk_i),
    .rst_uarch_ni   (rst_uarch_ni),
    .flush_i        (flush_i),
    .instr          (instr),
    .issue_ack_i    (issue_ack_o),
    .operand_a_i    (operand_a_n),
    .operand_b_i    (operand_b_n),
    .imm_i          (imm_n),
    .operand_a_o    (operand_a_o),
    .operand_b_o    (operand_b_o),
    .imm_o          (imm_o),
    .fu_o           (fu_o),
    .op_o           (op_o),
    .trans_id_o     (trans_id_o),
    .pc_o           (pc_o),
    .alu_valid_o    (alu_valid_o),
    .branch_valid_o (branch_valid_o),
    .mult_valid_o   (mult_valid_o),
    .lsu_valid_o    (lsu_valid_o),
    .csr_valid_o    (csr_valid_o)
  );

endmodule

/* tb/issue_model.svh */
/*
 * reference model for the issue stage testbench
 * mirrors the register file and predicts ack, stall, operands and unit valids
 */
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

  // mirror of the architectural registers
  logic [XLEN-1:0] mirror_regs [NR_REGS];

  task automatic mirror_reset();
    for (int r = 0; r < NR_REGS; r++) begin
      mirror_regs[r] = '0;
    end
  endtask

  // commit ports in order, later port overwrites, x0 stays zero
  task automatic mirror_commit();
    for (int p = 0; p < NR_CP; p++) begin
      if (we[p] && (waddr[p] != '0)) begin
        mirror_regs[waddr[p]] = wdata[p];
      end
    end
  endtask

  function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] idx);
    return (idx == '0) ? '0 : mirror_regs[idx];
  endfunction

  // ignore is set for rs1 when it carries a zimm
  function automatic logic src_hazard(input logic [REG_ADDR_W-1:0] idx, input logic ignore);
    return !ignore && (clobber[idx] != NONE);
  endfunction

  function automatic logic src_forward(input logic [REG_ADDR_W-1:0] idx, input logic ignore,
                                       input logic fwd_ok);
    return src_hazard(idx, ignore) && fwd_ok && (clobber[idx] != CSR);
  endfunction

  function automatic logic predict_stall();
    logic s1;
    logic s2;
    s1 = src_hazard(rs1, use_zimm) && !src_forward(rs1, use_zimm, fwd_rs1_valid);
    s2 = src_hazard(rs2, 1'b0) && !src_forward(rs2, 1'b0, fwd_rs2_valid);
    return stall | s1 | s2;
  endfunction

  function automatic logic predict_ack();
    logic busy;
    logic rd_free;
    logic ack;
    case (fu)
      ALU, CTRL_FLOW, CSR, MULT: busy = !flu_ready;
      LOAD, STORE:               busy = !lsu_ready;
      default:                   busy = 1'b0;
    endcase
    // pending writer on rd, unless it retires right now
    rd_free = (clobber[rd] == NONE);
    for (int p = 0; p < NR_CP; p++) begin
      if (we[p] && (waddr[p] == rd)) begin
        rd_free = 1'b1;
      end
    end
    ack = instr_valid && ((!predict_stall() && !busy && rd_free) || ex_valid || (fu == NONE));
    // expected mult valid of this cycle blocks the shared result bus
    if (exp_valids[2] && ((fu == ALU) || (fu == CTRL_FLOW) || (fu == CSR))) begin
      ack = 1'b0;
    end
    return ack;
  endfunction

  function automatic logic [XLEN-1:0] predict_operand_a();
    logic [XLEN-1:0] val;
    val = src_forward(rs1, use_zimm, fwd_rs1_valid) ? fwd_rs1_data : read_reg(rs1);
    if (use_pc) begin
      val = pc;
    end
    if (use_zimm) begin
      val = XLEN'(rs1);
    end
    return val;
  endfunction

  function automatic logic [XLEN-1:0] predict_operand_b();
    logic [XLEN-1:0] val;
    val = src_forward(rs2, 1'b0, fwd_rs2_valid) ? fwd_rs2_data : read_reg(rs2);
    if (use_imm && (fu != STORE) && (fu != CTRL_FLOW)) begin
      val = imm;
    end
    return val;
  endfunction

  // bit order alu, branch, mult, lsu, csr
  function automatic logic [4:0] predict_valids(input logic ack);
    logic [4:0] v;
    v = '0;
    if (instr_valid && ack && !ex_valid && !flush) begin
      case (fu)
        ALU:         v[4] = 1'b1;
        CTRL_FLOW:   v[3] = 1'b1;
        MULT:        v[2] = 1'b1;
        LOAD, STORE: v[1] = 1'b1;
        CSR:         v[0] = 1'b1;
        default:     v = '0;
      endcase
    end
    return v;
  endfunction

`endif

/* tb/tb_issue_read_operands.sv */
/*
 * testbench for the issue and read operands stage
 * random instructions, scoreboard state and commits checked against a model
 */
`timescale 1ns/1ns

module tb_issue_read_operands;
  import issue_pkg::*;

  localparam int unsigned XLEN = 32;
  localparam int unsigned NR_CP = 2;
  localparam int ACK_TIMEOUT = 64;
  localparam int NUM_INSTR = 500;

  logic clk = 1'b0;
  logic rst_n;
  logic flush;
  logic stall;
  // decoder side
  logic                  instr_valid;
  fu_t                   fu;
  logic [OP_W-1:0]       op;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       pc;
  logic                  use_pc;
  logic                  use_zimm;
  logic                  use_imm;
  logic                  ex_valid;
  logic [TRANS_ID_W-1:0] trans_id;
  // scoreboard side
  logic [XLEN-1:0]       fwd_rs1_data;
  logic                  fwd_rs1_valid;
  logic [XLEN-1:0]       fwd_rs2_data;
  logic                  fwd_rs2_valid;
  clobber_vec_t          clobber;
  logic                  flu_ready;
  logic                  lsu_ready;
  logic [NR_CP-1:0][REG_ADDR_W-1:0] waddr;
  logic [NR_CP-1:0][XLEN-1:0]       wdata;
  logic [NR_CP-1:0]                 we;
  // DUT outputs, valids ordered alu, branch, mult, lsu, csr
  logic                  issue_ack;
  logic                  stall_issue;
  logic [REG_ADDR_W-1:0] rs1_out;
  logic [REG_ADDR_W-1:0] rs2_out;
  logic [XLEN-1:0]       operand_a;
  logic [XLEN-1:0]       operand_b;
  logic [XLEN-1:0]       imm_out;
  fu_t                   fu_out;
  logic [OP_W-1:0]       op_out;
  logic [TRANS_ID_W-1:0] trans_id_out;
  logic [XLEN-1:0]       pc_out;
  logic [4:0]            valids_out;
  // expected registered outputs
  logic [XLEN-1:0]       exp_opa;
  logic [XLEN-1:0]       exp_opb;
  logic [XLEN-1:0]       exp_imm;
  fu_t                   exp_fu;
  logic [OP_W-1:0]       exp_op;
  logic [TRANS_ID_W-1:0] exp_tid;
  logic [XLEN-1:0]       exp_pc;
  logic [4:0]            exp_valids;
  int                    checks = 0;
  int                    errors = 0;
  bit                    timed_out = 1'b0;

  `include "issue_model.svh"

  always #2 clk = ~clk;

  issue_read_operands #(
    .XLEN            (XLEN),
    .NR_COMMIT_PORTS (NR_CP)
  ) issue_read_operands_i (
    .clk_i (clk), .rst_uarch_ni (rst_n), .flush_i (flush), .stall_i (stall),
    .instr_valid_i (instr_valid), .fu_i (fu), .op_i (op), .rs1_i (rs1), .rs2_i (rs2),
    .rd_i (rd), .imm_i (imm), .pc_i (pc), .use_pc_i (use_pc), .use_zimm_i (use_zimm),
    .use_imm_i (use_imm), .ex_valid_i (ex_valid), .trans_id_i (trans_id),
    .issue_ack_o (issue_ack), .stall_issue_o (stall_issue),
    .rs1_o (rs1_out), .rs2_o (rs2_out),
    .fwd_rs1_data_i (fwd_rs1_data), .fwd_rs1_valid_i (fwd_rs1_valid),
    .fwd_rs2_data_i (fwd_rs2_data), .fwd_rs2_valid_i (fwd_rs2_valid),
    .clobber_i (clobber), .flu_ready_i (flu_ready), .lsu_ready_i (lsu_ready),
    .waddr_i (waddr), .wdata_i (wdata), .we_i (we),
    .operand_a_o (operand_a), .operand_b_o (operand_b), .imm_o (imm_out),
    .fu_o (fu_out), .op_o (op_out), .trans_id_o (trans_id_out), .pc_o (pc_out),
    .alu_valid_o (valids_out[4]), .branch_valid_o (valids_out[3]),
    .mult_valid_o (valids_out[2]), .lsu_valid_o (valids_out[1]),
    .csr_valid_o (valids_out[0])
  );

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic randomize_instr();
    fu       = fu_t'(3'($urandom_range(6)));
    op       = OP_W'($urandom);
    // bias sources toward x0
    rs1      = ($urandom_range(7) == 0) ? '0 : REG_ADDR_W'($urandom);
    rs2      = ($urandom_range(7) == 0) ? '0 : REG_ADDR_W'($urandom);
    rd       = REG_ADDR_W'($urandom);
    imm      = XLEN'($urandom);
    pc       = XLEN'($urandom);
    use_pc   = ($urandom_range(3) == 0);
    use_zimm = ($urandom_range(7) == 0);
    use_imm  = ($urandom_range(1) == 1);
    ex_valid = ($urandom_range(7) == 0);
    trans_id = TRANS_ID_W'($urandom);
  endtask

  // scoreboard, unit ready and commit traffic, new every cycle
  task automatic randomize_env();
    stall         = ($urandom_range(7) == 0);
    flush         = ($urandom_range(15) == 0);
    flu_ready     = ($urandom_range(7) != 0);
    lsu_ready     = ($urandom_range(7) != 0);
    fwd_rs1_valid = ($urandom_range(3) != 0);
    fwd_rs2_valid = ($urandom_range(3) != 0);
    fwd_rs1_data  = XLEN'($urandom);
    fwd_rs2_data  = XLEN'($urandom);
    // sparse pending writers
    for (int r = 0; r < NR_REGS; r++) begin
      clobber[r] = ($urandom_range(9) == 0) ? fu_t'(3'($urandom_range(6, 1))) : NONE;
    end
    for (int p = 0; p < NR_CP; p++) begin
      we[p]    = ($urandom_range(1) == 1);
      waddr[p] = REG_ADDR_W'($urandom);
      wdata[p] = XLEN'($urandom);
    end
    // commit on rd now and then, exercises the WAW bypass
    if ($urandom_range(3) == 0) begin
      we[0]    = 1'b1;
      waddr[0] = rd;
    end
  endtask

  // called 1 ns after an edge, returns 1 ns after the next one
  task automatic run_cycle(output logic acked);
    logic exp_ack;
    #2;
    exp_ack = predict_ack();
    check_value("issue_ack_o", XLEN'(issue_ack), XLEN'(exp_ack));
    check_value("stall_issue_o", XLEN'(stall_issue), XLEN'(predict_stall()));
    check_value("rs1_o", XLEN'(rs1_out), XLEN'(rs1));
    check_value("rs2_o", XLEN'(rs2_out), XLEN'(rs2));
    acked = instr_valid && issue_ack;
    // register file is read before this cycle's commit lands
    exp_valids = predict_valids(exp_ack);
    exp_opa    = predict_operand_a();
    exp_opb    = predict_operand_b();
    exp_imm    = imm;
    exp_fu     = fu;
    exp_op     = op;
    exp_tid    = trans_id;
    exp_pc     = pc;
    mirror_commit();
    @(posedge clk);
    #1;
    check_value("operand_a_o", operand_a, exp_opa);
    check_value("operand_b_o", operand_b, exp_opb);
    check_value("imm_o", imm_out, exp_imm);
    check_value("fu_o", XLEN'(fu_out), XLEN'(exp_fu));
    check_value("op_o", XLEN'(op_out), XLEN'(exp_op));
    check_value("trans_id_o", XLEN'(trans_id_out), XLEN'(exp_tid));
    check_value("pc_o", pc_out, exp_pc);
    check_value("unit valids", XLEN'(valids_out), XLEN'(exp_valids));
  endtask

  task automatic idle_cycle();
    logic acked;
    randomize_instr();
    instr_valid = 1'b0;
    randomize_env();
    run_cycle(acked);
  endtask

  // hold one instruction until the stage takes it
  task automatic issue_instr();
    logic acked;
    int   waited;
    randomize_instr();
    instr_valid = 1'b1;
    acked = 1'b0;
    waited = 0;
    while (!acked && (waited < ACK_TIMEOUT)) begin
      randomize_env();
      run_cycle(acked);
      waited++;
    end
    if (!acked) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: instruction with trans_id %0d not acknowledged after %0d cycles",
               trans_id, ACK_TIMEOUT);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(9));
    rst_n = 1'b0;
    flush = 1'b0;
    stall = 1'b0;
    instr_valid = 1'b0;
    fu = NONE;
    op = '0;
    rs1 = '0;
    rs2 = '0;
    rd = '0;
    imm = '0;
    pc = '0;
    use_pc = 1'b0;
    use_zimm = 1'b0;
    use_imm = 1'b0;
    ex_valid = 1'b0;
    trans_id = '0;
    fwd_rs1_data = '0;
    fwd_rs1_valid = 1'b0;
    fwd_rs2_data = '0;
    fwd_rs2_valid = 1'b0;
    for (int r = 0; r < NR_REGS; r++) begin
      clobber[r] = NONE;
    end
    flu_ready = 1'b1;
    lsu_ready = 1'b1;
    waddr = '0;
    wdata = '0;
    we = '0;
    exp_valids = '0;
    mirror_reset();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // stage comes out of reset idle
    check_value("unit valids after reset", XLEN'(valids_out), '0);
    check_value("fu_o after reset", XLEN'(fu_out), XLEN'(NONE));
    check_value("operand_a_o after reset", operand_a, '0);
    check_value("operand_b_o after reset", operand_b, '0);
    for (int n = 0; (n < NUM_INSTR) && !timed_out; n++) begin
      if ($urandom_range(3) == 0) begin
        idle_cycle();
      end
      issue_instr();
    end
    if (!timed_out) begin
      idle_cycle();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+tb
design/issue_pkg.sv
design/issue_instr_if.sv
design/int_regfile.sv
design/hazard_check.sv
design/operand_select.sv
design/fu_dispatch.sv
design/issue_read_operands.sv
tb/tb_issue_read_operands.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_issue_read_operands

verilator --binary --timing --assert -f all.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
